//--- source/exec_pkg.sv
package exec_pkg;

    localparam int xlen         = 32;
    localparam int op_w         = 5;
    localparam int reg_addr_w   = 5;
    localparam int muldiv_steps = 32;
    localparam int step_w       = $clog2(muldiv_steps + 1);
    localparam int shamt_w      = $clog2(xlen);

    typedef enum logic [op_w-1:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLL,
        OP_SRL,
        OP_SRA,
        OP_SLT,
        OP_SLTU,
        OP_JALR,
        OP_COPY1,
        OP_BEQ,
        OP_BNE,
        OP_BLT,
        OP_BGE,
        OP_BLTU,
        OP_BGEU,
        OP_MUL,
        OP_MULH,
        OP_MULHSU,
        OP_MULHU,
        OP_DIV,
        OP_DIVU,
        OP_REM,
        OP_REMU,
        OP_NOP
    } exec_op_e;

    typedef enum logic {
        ST_IDLE,
        ST_BUSY
    } exec_state_e;

endpackage

//--- source/muldiv_if.sv
`timescale 1ns/1ps

interface muldiv_if import exec_pkg::*; ();

    logic            start;
    logic            kill;
    exec_op_e        op;
    logic [xlen-1:0] a;
    logic [xlen-1:0] b;
    logic [xlen-1:0] result;
    logic            done;

    // control side issues work, unit side returns one result per start
    modport ctrl (
        output start, kill, op, a, b,
        input  result, done
    );

    modport unit (
        input  start, kill, op, a, b,
        output result, done
    );

endinterface

//--- source/step_counter.sv
`timescale 1ns/1ps

module step_counter import exec_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic load,
    input  logic kill,
    output logic busy,
    output logic last
);

    logic [step_w-1:0] count;

    always_ff @(posedge clk) begin
        if (rst || kill) begin
            count <= '0;
            last  <= 1'b0;
        end else begin
            // final step happens on the edge leaving count 1
            last <= (count == step_w'(1));
            if (load) begin
                count <= step_w'(muldiv_steps);
            end else if (busy) begin
                count <= count - step_w'(1);
            end
        end
    end

    assign busy = (count != '0);

endmodule

//--- source/muldiv_unit.sv
`timescale 1ns/1ps

module muldiv_unit import exec_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    muldiv_if.unit md
);

    logic              start_ok;
    logic              busy;
    logic              last;
    logic              sign_a;
    logic              sign_b;
    logic              div_op;
    logic              hi_op;
    logic              neg_a;
    logic              neg_b;
    logic              neg_res;
    logic [xlen-1:0]   a_mag;
    logic [xlen-1:0]   b_mag;
    logic [xlen-1:0]   acc_hi;
    logic [xlen-1:0]   acc_lo;
    logic [xlen-1:0]   opnd;
    logic              div_q;
    logic              hi_q;
    logic              neg_q;
    logic [xlen:0]     add_a;
    logic [xlen:0]     add_b;
    logic [xlen+1:0]   add_sum;
    logic              ge;
    logic [xlen:0]     mul_sel;
    logic [2*xlen-1:0] prod;
    logic [2*xlen-1:0] prod_fix;
    logic [xlen-1:0]   div_raw;

    assign start_ok = md.start && !busy;

    step_counter counter_i (
        .clk  (clk),
        .rst  (rst),
        .load (start_ok),
        .kill (md.kill),
        .busy (busy),
        .last (last)
    );

    always_comb begin
        sign_a = 1'b0;
        sign_b = 1'b0;
        div_op = 1'b0;
        hi_op  = 1'b0;
        case (md.op)
            OP_MUL:    {sign_a, sign_b}                = 2'b11;
            OP_MULH:   {sign_a, sign_b, hi_op}         = 3'b111;
            OP_MULHSU: {sign_a, hi_op}                 = 2'b11;
            OP_MULHU:  hi_op                           = 1'b1;
            OP_DIV:    {sign_a, sign_b, div_op}        = 3'b111;
            OP_DIVU:   div_op                          = 1'b1;
            OP_REM:    {sign_a, sign_b, div_op, hi_op} = 4'b1111;
            OP_REMU:   {div_op, hi_op}                 = 2'b11;
            default:   ;
        endcase
    end

    assign neg_a = sign_a && md.a[xlen-1];
    assign neg_b = sign_b && md.b[xlen-1];
    assign a_mag = neg_a ? -md.a : md.a;
    assign b_mag = neg_b ? -md.b : md.b;

    // divide by zero keeps the all-ones quotient unsigned
    // overflow needs nothing, 2^31 negated wraps back to the dividend
    always_comb begin
        if (div_op && hi_op) begin
            neg_res = neg_a;
        end else if (div_op) begin
            neg_res = (neg_a ^ neg_b) && (md.b != '0);
        end else begin
            neg_res = neg_a ^ neg_b;
        end
    end

    // one adder serves both, subtract for the divide trial
    assign add_a   = div_q ? {acc_hi, acc_lo[xlen-1]} : {1'b0, acc_hi};
    assign add_b   = div_q ? ~{1'b0, opnd} : {1'b0, opnd};
    assign add_sum = {1'b0, add_a} + {1'b0, add_b} + {{(xlen+1){1'b0}}, div_q};
    assign ge      = add_sum[xlen+1];
    assign mul_sel = acc_lo[0] ? add_sum[xlen:0] : {1'b0, acc_hi};

    always_ff @(posedge clk) begin
        if (start_ok) begin
            div_q  <= div_op;
            hi_q   <= hi_op;
            neg_q  <= neg_res;
            acc_hi <= '0;
            acc_lo <= div_op ? a_mag : b_mag;
            opnd   <= div_op ? b_mag : a_mag;
        end else if (busy) begin
            if (div_q) begin
                acc_hi <= ge ? add_sum[xlen-1:0] : add_a[xlen-1:0];
                acc_lo <= {acc_lo[xlen-2:0], ge};
            end else begin
                acc_hi <= mul_sel[xlen:1];
                acc_lo <= {mul_sel[0], acc_lo[xlen-1:1]};
            end
        end
    end

    assign prod     = {acc_hi, acc_lo};
    assign prod_fix = neg_q ? -prod : prod;
    // remainder sits in the high half, quotient in the low half
    assign div_raw  = hi_q ? acc_hi : acc_lo;

    always_comb begin
        if (div_q) begin
            md.result = neg_q ? -div_raw : div_raw;
        end else begin
            md.result = hi_q ? prod_fix[2*xlen-1:xlen] : prod_fix[xlen-1:0];
        end
    end

    assign md.done = last;

endmodule

//--- source/alu_branch.sv
`timescale 1ns/1ps

module alu_branch import exec_pkg::*; (
    input  exec_op_e        op,
    input  logic [xlen-1:0] a,
    input  logic [xlen-1:0] b,
    input  logic [xlen-1:0] pc,
    input  logic [xlen-1:0] imm_b,
    output logic [xlen-1:0] result,
    output logic            taken,
    output logic [xlen-1:0] target
);

    logic [xlen-1:0]    sum;
    logic [shamt_w-1:0] shamt;
    logic               eq;
    logic               lt;
    logic               ltu;

    assign sum   = a + b;
    assign shamt = b[shamt_w-1:0];
    assign eq    = (a == b);
    assign lt    = ($signed(a) < $signed(b));
    assign ltu   = (a < b);

    always_comb begin
        case (op)
            OP_ADD:   result = sum;
            OP_SUB:   result = a - b;
            OP_AND:   result = a & b;
            OP_OR:    result = a | b;
            OP_XOR:   result = a ^ b;
            OP_SLL:   result = a << shamt;
            OP_SRL:   result = a >> shamt;
            OP_SRA:   result = $unsigned($signed(a) >>> shamt);
            OP_SLT:   result = {{(xlen-1){1'b0}}, lt};
            OP_SLTU:  result = {{(xlen-1){1'b0}}, ltu};
            OP_JALR:  result = {sum[xlen-1:1], 1'b0};
            OP_COPY1: result = a;
            default:  result = '0;
        endcase
    end

    always_comb begin
        case (op)
            OP_BEQ:  taken = eq;
            OP_BNE:  taken = !eq;
            OP_BLT:  taken = lt;
            OP_BGE:  taken = !lt;
            OP_BLTU: taken = ltu;
            OP_BGEU: taken = !ltu;
            default: taken = 1'b0;
        endcase
    end

    assign target = pc + imm_b;

endmodule

//--- source/exec_ctrl.sv
`timescale 1ns/1ps

module exec_ctrl import exec_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  flush,
    input  logic                  mem_stall,
    input  logic                  in_valid,
    input  exec_op_e              in_op,
    input  logic [xlen-1:0]       in_a,
    input  logic [xlen-1:0]       in_b,
    input  logic [reg_addr_w-1:0] in_rd,
    input  logic                  in_rf_wen,
    output logic                  stall,
    output logic                  load_alu,
    output logic                  load_md,
    output logic [xlen-1:0]       md_result,
    output logic [reg_addr_w-1:0] md_rd,
    output logic                  md_rf_wen,
    muldiv_if.ctrl                md
);

    exec_state_e           state;
    logic                  pending;
    logic                  start_q;
    exec_op_e              op_q;
    logic [xlen-1:0]       a_q;
    logic [xlen-1:0]       b_q;
    logic [xlen-1:0]       res_q;
    logic [reg_addr_w-1:0] rd_q;
    logic                  rf_wen_q;
    logic                  is_md;
    logic                  accept;

    always_comb begin
        case (in_op)
            OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU,
            OP_DIV, OP_DIVU, OP_REM, OP_REMU: is_md = 1'b1;
            default:                          is_md = 1'b0;
        endcase
    end

    assign accept   = in_valid && !stall && !mem_stall && !flush;
    assign stall    = (state == ST_BUSY);
    assign load_alu = accept && !is_md;
    // result is either fresh from the unit or parked during mem_stall
    assign load_md  = stall && (pending || md.done) && !mem_stall && !flush;

    assign md_result = pending ? res_q : md.result;
    assign md_rd     = rd_q;
    assign md_rf_wen = rf_wen_q;

    assign md.start = start_q;
    assign md.kill  = flush;
    assign md.op    = op_q;
    assign md.a     = a_q;
    assign md.b     = b_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= ST_IDLE;
            pending <= 1'b0;
            start_q <= 1'b0;
        end else begin
            start_q <= 1'b0;
            if (flush) begin
                state   <= ST_IDLE;
                pending <= 1'b0;
            end else begin
                case (state)
                    ST_IDLE: begin
                        if (accept && is_md) begin
                            state   <= ST_BUSY;
                            start_q <= 1'b1;
                        end
                    end
                    ST_BUSY: begin
                        if (load_md) begin
                            state   <= ST_IDLE;
                            pending <= 1'b0;
                        end else if (md.done) begin
                            pending <= 1'b1;
                        end
                    end
                endcase
            end
        end
    end

    // operand latch, the source moves on once accepted
    always_ff @(posedge clk) begin
        if (accept && is_md) begin
            op_q     <= in_op;
            a_q      <= in_a;
            b_q      <= in_b;
            rd_q     <= in_rd;
            rf_wen_q <= in_rf_wen;
        end
        if (md.done) begin
            res_q <= md.result;
        end
    end

endmodule

//--- source/execute_stage.sv
`timescale 1ns/1ps

module execute_stage import exec_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  flush,
    input  logic                  mem_stall,
    input  logic                  in_valid,
    input  exec_op_e              in_op,
    input  logic [xlen-1:0]       in_a,
    input  logic [xlen-1:0]       in_b,
    input  logic [xlen-1:0]       in_pc,
    input  logic [xlen-1:0]       in_imm_b,
    input  logic [reg_addr_w-1:0] in_rd,
    input  logic                  in_rf_wen,
    output logic                  out_valid,
    output logic                  br_flg,
    output logic                  out_rf_wen,
    output logic                  stall,
    output logic [xlen-1:0]       alu_out,
    output logic [xlen-1:0]       br_target,
    output logic [reg_addr_w-1:0] out_rd
);

    logic                  load_alu;
    logic                  load_md;
    logic [xlen-1:0]       md_result;
    logic [reg_addr_w-1:0] md_rd;
    logic                  md_rf_wen;
    logic [xlen-1:0]       alu_result;
    logic                  alu_taken;
    logic [xlen-1:0]       alu_target;

    muldiv_if md_if ();

    exec_ctrl ctrl_i (
        .clk       (clk),
        .rst       (rst),
        .flush     (flush),
        .mem_stall (mem_stall),
        .in_valid  (in_valid),
        .in_op     (in_op),
        .in_a      (in_a),
        .in_b      (in_b),
        .in_rd     (in_rd),
        .in_rf_wen (in_rf_wen),
        .stall     (stall),
        .load_alu  (load_alu),
        .load_md   (load_md),
        .md_result (md_result),
        .md_rd     (md_rd),
        .md_rf_wen (md_rf_wen),
        .md        (md_if.ctrl)
    );

    muldiv_unit md_i (
        .clk (clk),
        .rst (rst),
        .md  (md_if.unit)
    );

    alu_branch alu_i (
        .op     (in_op),
        .a      (in_a),
        .b      (in_b),
        .pc     (in_pc),
        .imm_b  (in_imm_b),
        .result (alu_result),
        .taken  (alu_taken),
        .target (alu_target)
    );

    // load_alu and load_md never coincide, alu loads only while idle
    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid  <= 1'b0;
            out_rf_wen <= 1'b0;
            br_flg     <= 1'b0;
        end else if (load_alu) begin
            out_valid  <= 1'b1;
            out_rf_wen <= in_rf_wen;
            br_flg     <= alu_taken;
        end else if (load_md) begin
            out_valid  <= 1'b1;
            out_rf_wen <= md_rf_wen;
            br_flg     <= 1'b0;
        end else begin
            // bubble
            out_valid <= 1'b0;
            if (flush) begin
                out_rf_wen <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load_alu) begin
            alu_out   <= alu_result;
            br_target <= alu_target;
            out_rd    <= in_rd;
        end else if (load_md) begin
            alu_out <= md_result;
            out_rd  <= md_rd;
        end
    end

endmodule

//--- test/exec_model.svh
`ifndef EXEC_MODEL_SVH
`define EXEC_MODEL_SVH

function automatic logic is_muldiv(input exec_op_e op);
    return (op >= OP_MUL) && (op <= OP_REMU);
endfunction

// expected alu_out, from the RV32IM rules
function automatic logic [xlen-1:0] model_result(input exec_op_e op, input logic [xlen-1:0] a,
                                                 input logic [xlen-1:0] b);
    logic [4:0]             sh;
    logic signed [xlen-1:0] sa;
    logic signed [xlen-1:0] sb;
    logic [2*xlen-1:0]      ext_a;
    logic [2*xlen-1:0]      ext_b;
    logic [2*xlen-1:0]      prod;
    logic                   ovf;
    sh    = b[4:0];
    sa    = a;
    sb    = b;
    // mulhu takes a unsigned, only mulh takes b signed
    ext_a = (op == OP_MULHU) ? {{xlen{1'b0}}, a} : {{xlen{a[xlen-1]}}, a};
    ext_b = (op == OP_MULH) ? {{xlen{b[xlen-1]}}, b} : {{xlen{1'b0}}, b};
    prod  = ext_a * ext_b;
    ovf   = (a == {1'b1, {(xlen-1){1'b0}}}) && (b == '1);
    case (op)
        OP_ADD:   return a + b;
        OP_SUB:   return a - b;
        OP_AND:   return a & b;
        OP_OR:    return a | b;
        OP_XOR:   return a ^ b;
        OP_SLL:   return a << sh;
        OP_SRL:   return a >> sh;
        OP_SRA:   return (a >> sh) | (a[xlen-1] ? ~({xlen{1'b1}} >> sh) : '0);
        OP_SLT:   return {{(xlen-1){1'b0}}, sa < sb};
        OP_SLTU:  return {{(xlen-1){1'b0}}, a < b};
        OP_JALR:  return (a + b) & ~xlen'(1);
        OP_COPY1: return a;
        OP_MUL:   return prod[xlen-1:0];
        OP_MULH, OP_MULHSU, OP_MULHU: return prod[2*xlen-1:xlen];
        OP_DIV: begin
            if (b == '0) return '1;
            if (ovf) return a;
            return sa / sb;
        end
        OP_DIVU:  return (b == '0) ? '1 : a / b;
        OP_REM: begin
            if (b == '0) return a;
            if (ovf) return '0;
            return sa % sb;
        end
        OP_REMU:  return (b == '0) ? a : a % b;
        default:  return '0;
    endcase
endfunction

function automatic logic model_taken(input exec_op_e op, input logic [xlen-1:0] a,
                                     input logic [xlen-1:0] b);
    case (op)
        OP_BEQ:  return a == b;
        OP_BNE:  return a != b;
        OP_BLT:  return $signed(a) < $signed(b);
        OP_BGE:  return $signed(a) >= $signed(b);
        OP_BLTU: return a < b;
        OP_BGEU: return a >= b;
        default: return 1'b0;
    endcase
endfunction

`endif

//--- test/tb_execute_stage.sv
`timescale 1ns/1ps

module tb_execute_stage import exec_pkg::*; ();

    `include "exec_model.svh"

    localparam int result_timeout = 100;
    localparam int issue_timeout  = 100;
    localparam int drain_timeout  = 200;

    typedef struct packed {
        exec_op_e              op;
        logic [xlen-1:0]       result;
        logic                  taken;
        logic [xlen-1:0]       target;
        logic [reg_addr_w-1:0] rd;
        logic                  rf_wen;
    } expect_t;

    logic                  clk;
    logic                  rst;
    logic                  flush;
    logic                  mem_stall;
    logic                  in_valid;
    exec_op_e              in_op;
    logic [xlen-1:0]       in_a;
    logic [xlen-1:0]       in_b;
    logic [xlen-1:0]       in_pc;
    logic [xlen-1:0]       in_imm_b;
    logic [reg_addr_w-1:0] in_rd;
    logic                  in_rf_wen;
    logic                  out_valid;
    logic                  br_flg;
    logic                  out_rf_wen;
    logic                  stall;
    logic [xlen-1:0]       alu_out;
    logic [xlen-1:0]       br_target;
    logic [reg_addr_w-1:0] out_rd;

    expect_t exp_q[$];
    integer  seed = 67496;
    string   test_name;
    int      mismatches = 0;
    int      other_errors = 0;
    int      checked = 0;
    int      wait_cycles = 0;
    logic    stall_seen;
    logic    prev_flush;
    logic    prev_ms;
    logic    timed_out;

    execute_stage dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic check_data(input string field, input logic [xlen-1:0] exp_v,
                              input logic [xlen-1:0] act_v);
        if (act_v !== exp_v) begin
            mismatches++;
            $display("mismatch %s %s: expected %h, actual %h", test_name, field, exp_v, act_v);
        end
    endtask

    task automatic check_flag(input string field, input logic exp_v, input logic act_v);
        if (act_v !== exp_v) begin
            mismatches++;
            $display("mismatch %s %s: expected %b, actual %b", test_name, field, exp_v, act_v);
        end
    endtask

    task automatic check_reg(input string field, input logic [reg_addr_w-1:0] exp_v,
                             input logic [reg_addr_w-1:0] act_v);
        if (act_v !== exp_v) begin
            mismatches++;
            $display("mismatch %s %s: expected %h, actual %h", test_name, field, exp_v, act_v);
        end
    endtask

    function automatic logic [xlen-1:0] pick_operand();
        case ($unsigned($random(seed)) % 8)
            0:       return '0;
            1:       return '1;
            2:       return {1'b1, {(xlen-1){1'b0}}};
            3:       return xlen'(1);
            default: return $random(seed);
        endcase
    endfunction

    task automatic sample_outputs();
        expect_t e;
        if (stall) stall_seen = 1'b1;
        if (prev_flush) begin
            check_flag("out_valid after flush", 1'b0, out_valid);
            check_flag("out_rf_wen after flush", 1'b0, out_rf_wen);
            check_flag("stall after flush", 1'b0, stall);
        end
        if (prev_ms) check_flag("out_valid after mem_stall", 1'b0, out_valid);
        if (out_valid) begin
            if (exp_q.size() == 0) begin
                other_errors++;
                $display("%s: out_valid with no instruction outstanding", test_name);
            end else begin
                e = exp_q.pop_front();
                wait_cycles = 0;
                checked++;
                check_data("alu_out", e.result, alu_out);
                check_flag("br_flg", e.taken, br_flg);
                check_reg("out_rd", e.rd, out_rd);
                check_flag("out_rf_wen", e.rf_wen, out_rf_wen);
                if (!is_muldiv(e.op)) begin
                    check_data("br_target", e.target, br_target);
                end else if (!stall_seen) begin
                    other_errors++;
                    $display("%s: stall never rose before a multicycle result", test_name);
                end
            end
        end else if (exp_q.size() != 0) begin
            wait_cycles++;
            if (wait_cycles > result_timeout && !timed_out) begin
                other_errors++;
                timed_out = 1'b1;
                $display("%s: no out_valid within %0d cycles", test_name, result_timeout);
            end
        end
    endtask

    // one cycle: drive, track the scoreboard, then sample after the edge
    task automatic apply(input logic valid, input exec_op_e op, input logic [xlen-1:0] a,
                         input logic [xlen-1:0] b, input logic [xlen-1:0] pc,
                         input logic [xlen-1:0] imm, input logic [reg_addr_w-1:0] rd,
                         input logic wen, input logic ms, input logic fl, output logic accepted);
        expect_t e;
        in_valid  = valid;
        in_op     = op;
        in_a      = a;
        in_b      = b;
        in_pc     = pc;
        in_imm_b  = imm;
        in_rd     = rd;
        in_rf_wen = wen;
        mem_stall = ms;
        flush     = fl;
        accepted  = valid && !stall && !ms && !fl;
        // flush while busy drops the multicycle op at the back
        if (fl && stall && exp_q.size() != 0) e = exp_q.pop_back();
        if (accepted) begin
            if (exp_q.size() == 0) wait_cycles = 0;
            e.op     = op;
            e.result = model_result(op, a, b);
            e.taken  = model_taken(op, a, b);
            e.target = pc + imm;
            e.rd     = rd;
            e.rf_wen = wen;
            exp_q.push_back(e);
            if (is_muldiv(op)) stall_seen = 1'b0;
        end
        prev_flush = fl;
        prev_ms    = ms;
        @(posedge clk);
        #1;
        sample_outputs();
    endtask

    task automatic idle_cycle();
        logic acc;
        apply(1'b0, OP_NOP, '0, '0, '0, '0, '0, 1'b0, 1'b0, 1'b0, acc);
    endtask

    task automatic run_random(input string name, input int kind, input int cycles,
                              input int ms_pct, input int fl_pct);
        int       n;
        int       pick;
        exec_op_e op;
        logic     acc;
        test_name = name;
        for (n = 0; n < cycles && !timed_out; n++) begin
            pick = $unsigned($random(seed)) % 27;
            case (kind)
                0:       op = exec_op_e'(op_w'(pick % 12));
                1:       op = exec_op_e'(op_w'(int'(OP_BEQ) + pick % 6));
                2:       op = exec_op_e'(op_w'(int'(OP_MUL) + pick % 8));
                default: op = exec_op_e'(op_w'(pick));
            endcase
            apply(($unsigned($random(seed)) % 8) != 0, op, pick_operand(), pick_operand(),
                  $random(seed), $random(seed), reg_addr_w'($random(seed)), 1'($random(seed)),
                  ($unsigned($random(seed)) % 100) < ms_pct,
                  ($unsigned($random(seed)) % 100) < fl_pct, acc);
        end
    endtask

    task automatic issue_one(input exec_op_e op, input logic [xlen-1:0] a,
                             input logic [xlen-1:0] b);
        int   n;
        logic acc;
        acc = 1'b0;
        for (n = 0; n < issue_timeout && !acc && !timed_out; n++) begin
            apply(1'b1, op, a, b, '0, '0, reg_addr_w'(n), 1'b1, 1'b0, 1'b0, acc);
        end
        if (!acc && !timed_out) begin
            other_errors++;
            timed_out = 1'b1;
            $display("%s: stall did not fall within %0d cycles", test_name, issue_timeout);
        end
    endtask

    task automatic drain();
        int n;
        for (n = 0; n < drain_timeout && (exp_q.size() != 0 || stall) && !timed_out; n++) begin
            idle_cycle();
        end
        if ((exp_q.size() != 0 || stall) && !timed_out) begin
            other_errors++;
            timed_out = 1'b1;
            $display("%s: results still outstanding at the end of the run", test_name);
        end
    endtask

    initial begin
        int              i;
        int              k;
        logic [xlen-1:0] corner_a [4];
        logic [xlen-1:0] corner_b [4];
        corner_a   = '{32'h8000_0000, 32'h1234_5678, 32'h0000_0000, 32'hffff_ffff};
        corner_b   = '{32'hffff_ffff, 32'h0000_0000, 32'h0000_0000, 32'h8000_0000};
        rst        = 1'b1;
        flush      = 1'b0;
        mem_stall  = 1'b0;
        in_valid   = 1'b0;
        in_op      = OP_NOP;
        in_a       = '0;
        in_b       = '0;
        in_pc      = '0;
        in_imm_b   = '0;
        in_rd      = '0;
        in_rf_wen  = 1'b0;
        stall_seen = 1'b0;
        prev_flush = 1'b0;
        prev_ms    = 1'b0;
        timed_out  = 1'b0;
        test_name  = "reset";
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        check_flag("out_valid", 1'b0, out_valid);
        check_flag("stall", 1'b0, stall);
        check_flag("out_rf_wen", 1'b0, out_rf_wen);
        for (i = 0; i < 3; i++) idle_cycle();

        run_random("alu", 0, 400, 0, 0);
        run_random("branch", 1, 300, 0, 0);
        // signed overflow and divide by zero for every multicycle op
        test_name = "muldiv corner";
        for (i = 0; i < 8 && !timed_out; i++) begin
            for (k = 0; k < 4; k++) begin
                issue_one(exec_op_e'(op_w'(int'(OP_MUL) + i)), corner_a[k], corner_b[k]);
            end
        end
        run_random("muldiv", 2, 2000, 0, 0);
        run_random("mem_stall", 3, 3000, 25, 0);
        run_random("flush", 3, 3000, 10, 4);
        if (!timed_out) drain();

        $display("summary: %0d results checked, %0d mismatches, %0d other errors",
                 checked, mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

//--- files.f
+incdir+test
source/exec_pkg.sv
source/muldiv_if.sv
source/step_counter.sv
source/muldiv_unit.sv
source/alu_branch.sv
source/exec_ctrl.sv
source/execute_stage.sv
test/tb_execute_stage.sv

//--- Makefile
TOP = tb_execute_stage

all: run

build:
	verilator --binary --timing -f files.f --top-module $(TOP) -Mdir obj_dir

run: build
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -x "all tests passed" > /dev/null

lint:
	verilator --lint-only -Wall --timing -f files.f --top-module execute_stage

clean:
	rm -rf obj_dir

.PHONY: all build run lint clean
